// ==== flist.f ====
+incdir+source
source/decodePkg.sv
source/specialDecoder.sv
source/branchDecoder.sv
source/immDecoder.sv
source/decodeRegister.sv
source/controlUnit.sv
tests/controlUnitTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module controlUnitTb \
    -Mdir obj_dir -o controlUnitSim
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

output=$(./obj_dir/controlUnitSim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit 1
fi

if echo "$output" | grep -q "Result: PASSED"; then
    exit 0
fi
exit 1

// ==== source/branchDecoder.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module branchDecoder (
    input  decodePkg::instrWord_u instr,
    output logic                  bMatch,
    output logic [`WSRC_W-1:0]    bSelWSource,
    output logic [`RDST_W-1:0]    bSelRegDest,
    output logic                  bWriteReg,
    output logic                  bWriteOv,
    output logic                  bSelImRegB,
    output logic                  bSelSaRegA,
    output logic                  bSelAluShift,
    output logic [`ALUOP_W-1:0]   bAluOp,
    output logic                  bUnsig,
    output logic [`SHOP_W-1:0]    bShiftOp,
    output logic [`MSEL_W-1:0]    bMsm,
    output logic [`MSEL_W-1:0]    bMsl,
    output logic                  bReadMem,
    output logic                  bWriteMem,
    output logic [`BRJ_W-1:0]     bSelBrJumpZ,
    output logic [`PCSEL_W-1:0]   bSelTipoPc,
    output logic [`CMP_W-1:0]     bCompOp
);

    logic link;

    always_comb begin
        bMatch = 1'b0;
        link = 1'b0;
        {bSelWSource, bSelRegDest, bWriteReg, bWriteOv, bSelImRegB, bSelSaRegA,
         bSelAluShift, bAluOp, bUnsig, bShiftOp, bMsm, bMsl, bReadMem, bWriteMem,
         bSelBrJumpZ, bSelTipoPc, bCompOp} = '0;
        case (instr.i.op)
            `OP_REGIMM: begin
                if (instr.i.rt inside {`RT_BLTZ, `RT_BGEZ, `RT_BLTZAL, `RT_BGEZAL}) begin
                    bMatch = 1'b1;
                    bSelBrJumpZ = `BRJ_BRANCH;
                    bSelTipoPc = `PC_BRANCH;
                    // rt bit 0 picks GEZ, bit 4 marks the linking forms
                    bCompOp = instr.i.rt[0] ? `CMP_GEZ : `CMP_LTZ;
                    link = instr.i.rt[4];
                end
            end
            `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ: begin
                bMatch = 1'b1;
                bSelBrJumpZ = `BRJ_BRANCH;
                bSelTipoPc = `PC_BRANCH;
                case (instr.i.op[1:0])
                    2'b00:   bCompOp = `CMP_EQ;
                    2'b01:   bCompOp = `CMP_NE;
                    2'b10:   bCompOp = `CMP_LEZ;
                    default: bCompOp = `CMP_GTZ;
                endcase
            end
            `OP_J, `OP_JAL: begin
                bMatch = 1'b1;
                bSelBrJumpZ = `BRJ_JUMP;
                bSelTipoPc = `PC_TARGET;
                link = instr.j.op[0];
            end
            default: ;
        endcase
        // Return address goes to ra
        if (link) begin
            bSelWSource = `WS_LINK;
            bSelRegDest = `RD_RA;
            bWriteReg = 1'b1;
            bWriteOv = 1'b1;
        end
    end

endmodule

// ==== source/controlUnit.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module controlUnit (
    input  logic                clk,
    input  logic                reset,
    input  logic                instrValid,
    input  logic [`INSTR_W-1:0] instr,
    output logic                ctrlValid,
    output logic [`WSRC_W-1:0]  selWSource,
    output logic [`RDST_W-1:0]  selRegDest,
    output logic                writeReg,
    output logic                writeOv,
    output logic                selImRegB,
    output logic                selSaRegA,
    output logic                selAluShift,
    output logic [`ALUOP_W-1:0] aluOp,
    output logic                unsig,
    output logic [`SHOP_W-1:0]  shiftOp,
    output logic [`MSEL_W-1:0]  msm,
    output logic [`MSEL_W-1:0]  msl,
    output logic                readMem,
    output logic                writeMem,
    output logic [`BRJ_W-1:0]   selBrJumpZ,
    output logic [`PCSEL_W-1:0] selTipoPc,
    output logic [`CMP_W-1:0]   compOp
);

    decodePkg::instrWord_u instrWord;

    logic                sMatch, bMatch, iMatch;
    logic [`WSRC_W-1:0]  sSelWSource, bSelWSource, iSelWSource;
    logic [`RDST_W-1:0]  sSelRegDest, bSelRegDest, iSelRegDest;
    logic                sWriteReg, bWriteReg, iWriteReg;
    logic                sWriteOv, bWriteOv, iWriteOv;
    logic                sSelImRegB, bSelImRegB, iSelImRegB;
    logic                sSelSaRegA, bSelSaRegA, iSelSaRegA;
    logic                sSelAluShift, bSelAluShift, iSelAluShift;
    logic [`ALUOP_W-1:0] sAluOp, bAluOp, iAluOp;
    logic                sUnsig, bUnsig, iUnsig;
    logic [`SHOP_W-1:0]  sShiftOp, bShiftOp, iShiftOp;
    logic [`MSEL_W-1:0]  sMsm, bMsm, iMsm;
    logic [`MSEL_W-1:0]  sMsl, bMsl, iMsl;
    logic                sReadMem, bReadMem, iReadMem;
    logic                sWriteMem, bWriteMem, iWriteMem;
    logic [`BRJ_W-1:0]   sSelBrJumpZ, bSelBrJumpZ, iSelBrJumpZ;
    logic [`PCSEL_W-1:0] sSelTipoPc, bSelTipoPc, iSelTipoPc;
    logic [`CMP_W-1:0]   sCompOp, bCompOp, iCompOp;

    // Decoders read the word through its field views
    assign instrWord = decodePkg::instrWord_u'(instr);

    specialDecoder u_specialDecoder (
        .instr(instrWord),
        .*
    );

    branchDecoder u_branchDecoder (
        .instr(instrWord),
        .*
    );

    immDecoder u_immDecoder (
        .instr(instrWord),
        .*
    );

    decodeRegister u_decodeRegister (
        .*
    );

endmodule

// ==== source/decodePkg.sv ====
`include "decode_macros.svh"

package decodePkg;

    // One instruction word seen as R, I or J form
    typedef union packed {
        struct packed {
            logic [`OP_W-1:0]  op;
            logic [`REG_W-1:0] rs;
            logic [`REG_W-1:0] rt;
            logic [`REG_W-1:0] rd;
            logic [`REG_W-1:0] shamt;
            logic [`FN_W-1:0]  fn;
        } r;
        struct packed {
            logic [`OP_W-1:0]  op;
            logic [`REG_W-1:0] rs;
            logic [`REG_W-1:0] rt;
            logic [`IMM_W-1:0] imm;
        } i;
        struct packed {
            logic [`OP_W-1:0]     op;
            logic [`TARGET_W-1:0] target;
        } j;
    } instrWord_u;

endpackage

// ==== source/decodeRegister.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module decodeRegister (
    input  logic                clk,
    input  logic                reset,
    input  logic                instrValid,
    input  logic                sMatch, bMatch, iMatch,
    input  logic [`WSRC_W-1:0]  sSelWSource, bSelWSource, iSelWSource,
    input  logic [`RDST_W-1:0]  sSelRegDest, bSelRegDest, iSelRegDest,
    input  logic                sWriteReg, bWriteReg, iWriteReg,
    input  logic                sWriteOv, bWriteOv, iWriteOv,
    input  logic                sSelImRegB, bSelImRegB, iSelImRegB,
    input  logic                sSelSaRegA, bSelSaRegA, iSelSaRegA,
    input  logic                sSelAluShift, bSelAluShift, iSelAluShift,
    input  logic [`ALUOP_W-1:0] sAluOp, bAluOp, iAluOp,
    input  logic                sUnsig, bUnsig, iUnsig,
    input  logic [`SHOP_W-1:0]  sShiftOp, bShiftOp, iShiftOp,
    input  logic [`MSEL_W-1:0]  sMsm, bMsm, iMsm,
    input  logic [`MSEL_W-1:0]  sMsl, bMsl, iMsl,
    input  logic                sReadMem, bReadMem, iReadMem,
    input  logic                sWriteMem, bWriteMem, iWriteMem,
    input  logic [`BRJ_W-1:0]   sSelBrJumpZ, bSelBrJumpZ, iSelBrJumpZ,
    input  logic [`PCSEL_W-1:0] sSelTipoPc, bSelTipoPc, iSelTipoPc,
    input  logic [`CMP_W-1:0]   sCompOp, bCompOp, iCompOp,
    output logic                ctrlValid,
    output logic [`WSRC_W-1:0]  selWSource,
    output logic [`RDST_W-1:0]  selRegDest,
    output logic                writeReg,
    output logic                writeOv,
    output logic                selImRegB,
    output logic                selSaRegA,
    output logic                selAluShift,
    output logic [`ALUOP_W-1:0] aluOp,
    output logic                unsig,
    output logic [`SHOP_W-1:0]  shiftOp,
    output logic [`MSEL_W-1:0]  msm,
    output logic [`MSEL_W-1:0]  msl,
    output logic                readMem,
    output logic                writeMem,
    output logic [`BRJ_W-1:0]   selBrJumpZ,
    output logic [`PCSEL_W-1:0] selTipoPc,
    output logic [`CMP_W-1:0]   compOp
);

    localparam int FieldsW = `WSRC_W + `RDST_W + `ALUOP_W + `SHOP_W + 2 * `MSEL_W
                           + `BRJ_W + `PCSEL_W + `CMP_W + 8;

    logic [FieldsW-1:0] sFields;
    logic [FieldsW-1:0] bFields;
    logic [FieldsW-1:0] iFields;
    logic [FieldsW-1:0] picked;

    assign sFields = {sSelWSource, sSelRegDest, sWriteReg, sWriteOv, sSelImRegB, sSelSaRegA,
                      sSelAluShift, sAluOp, sUnsig, sShiftOp, sMsm, sMsl, sReadMem,
                      sWriteMem, sSelBrJumpZ, sSelTipoPc, sCompOp};
    assign bFields = {bSelWSource, bSelRegDest, bWriteReg, bWriteOv, bSelImRegB, bSelSaRegA,
                      bSelAluShift, bAluOp, bUnsig, bShiftOp, bMsm, bMsl, bReadMem,
                      bWriteMem, bSelBrJumpZ, bSelTipoPc, bCompOp};
    assign iFields = {iSelWSource, iSelRegDest, iWriteReg, iWriteOv, iSelImRegB, iSelSaRegA,
                      iSelAluShift, iAluOp, iUnsig, iShiftOp, iMsm, iMsl, iReadMem,
                      iWriteMem, iSelBrJumpZ, iSelTipoPc, iCompOp};

    // One-hot select giving all zeros when nothing matched
    assign picked = ({FieldsW{sMatch}} & sFields)
                  | ({FieldsW{bMatch}} & bFields)
                  | ({FieldsW{iMatch}} & iFields);

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlValid <= 1'b0;
            {selWSource, selRegDest, writeReg, writeOv, selImRegB, selSaRegA, selAluShift,
             aluOp, unsig, shiftOp, msm, msl, readMem, writeMem, selBrJumpZ, selTipoPc,
             compOp} <= '0;
        end else begin
            ctrlValid <= instrValid;
            {selWSource, selRegDest, writeReg, writeOv, selImRegB, selSaRegA, selAluShift,
             aluOp, unsig, shiftOp, msm, msl, readMem, writeMem, selBrJumpZ, selTipoPc,
             compOp} <= picked;
            // An invalid word still decodes but must not write anything
            if (!instrValid) begin
                writeReg <= 1'b0;
                readMem <= 1'b0;
                writeMem <= 1'b0;
            end
        end
    end

    // The three decoders cover disjoint instructions
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({sMatch, bMatch, iMatch}));

    assert property (@(posedge clk) disable iff (reset)
        !(readMem && writeMem));

    assert property (@(posedge clk) disable iff (reset)
        !ctrlValid |-> !(writeReg || readMem || writeMem));

endmodule

// ==== source/decode_macros.svh ====
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// Instruction word fields
`define INSTR_W  32
`define OP_W     6
`define FN_W     6
`define REG_W    5
`define IMM_W    16
`define TARGET_W 26

// Control field widths
`define WSRC_W  3
`define RDST_W  2
`define ALUOP_W 3
`define SHOP_W  2
`define MSEL_W  3
`define BRJ_W   2
`define PCSEL_W 2
`define CMP_W   3

`define OP_SPECIAL 6'b000000
`define OP_REGIMM  6'b000001
`define OP_J       6'b000010
`define OP_JAL     6'b000011
`define OP_BEQ     6'b000100
`define OP_BNE     6'b000101
`define OP_BLEZ    6'b000110
`define OP_BGTZ    6'b000111
`define OP_ADDI    6'b001000
`define OP_ADDIU   6'b001001
`define OP_SLTI    6'b001010
`define OP_SLTIU   6'b001011
`define OP_ANDI    6'b001100
`define OP_ORI     6'b001101
`define OP_XORI    6'b001110
`define OP_LUI     6'b001111
`define OP_LB      6'b100000
`define OP_LH      6'b100001
`define OP_LW      6'b100011
`define OP_LBU     6'b100100
`define OP_LHU     6'b100101
`define OP_SB      6'b101000
`define OP_SH      6'b101001
`define OP_SW      6'b101011

// SPECIAL funct codes
`define FN_SLL  6'b000000
`define FN_SRL  6'b000010
`define FN_SRA  6'b000011
`define FN_SLLV 6'b000100
`define FN_SRLV 6'b000110
`define FN_SRAV 6'b000111
`define FN_JR   6'b001000
`define FN_JALR 6'b001001
`define FN_ADD  6'b100000
`define FN_ADDU 6'b100001
`define FN_SUB  6'b100010
`define FN_SUBU 6'b100011
`define FN_AND  6'b100100
`define FN_OR   6'b100101
`define FN_XOR  6'b100110
`define FN_NOR  6'b100111
`define FN_SLT  6'b101010
`define FN_SLTU 6'b101011

// REGIMM rt codes
`define RT_BLTZ   5'b00000
`define RT_BGEZ   5'b00001
`define RT_BLTZAL 5'b10000
`define RT_BGEZAL 5'b10001

`define ALU_AND 3'b000
`define ALU_OR  3'b001
`define ALU_ADD 3'b010
`define ALU_NOR 3'b100
`define ALU_XOR 3'b101
`define ALU_SUB 3'b110

`define SH_SRL 2'b00
`define SH_SRA 2'b01
`define SH_SLL 2'b10

`define CMP_EQ  3'b000
`define CMP_GEZ 3'b001
`define CMP_LEZ 3'b010
`define CMP_GTZ 3'b011
`define CMP_LTZ 3'b100
`define CMP_NE  3'b101

// Register write source and destination
`define WS_ALU  3'b000
`define WS_MEM  3'b001
`define WS_LUI  3'b010
`define WS_LINK 3'b011
`define WS_SLT  3'b100
`define RD_RT   2'b00
`define RD_RD   2'b01
`define RD_RA   2'b10

// Next PC kind and PC source
`define BRJ_JUMP   2'b01
`define BRJ_BRANCH 2'b10
`define PC_BRANCH  2'b00
`define PC_REG     2'b01
`define PC_TARGET  2'b10

// Byte-lane select codes for msm and msl
`define MS_SEL0 3'b000
`define MS_SEL1 3'b001
`define MS_SEL2 3'b010
`define MS_SEL3 3'b011
`define MS_SEL4 3'b100

`endif

// ==== source/immDecoder.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module immDecoder (
    input  decodePkg::instrWord_u instr,
    output logic                  iMatch,
    output logic [`WSRC_W-1:0]    iSelWSource,
    output logic [`RDST_W-1:0]    iSelRegDest,
    output logic                  iWriteReg,
    output logic                  iWriteOv,
    output logic                  iSelImRegB,
    output logic                  iSelSaRegA,
    output logic                  iSelAluShift,
    output logic [`ALUOP_W-1:0]   iAluOp,
    output logic                  iUnsig,
    output logic [`SHOP_W-1:0]    iShiftOp,
    output logic [`MSEL_W-1:0]    iMsm,
    output logic [`MSEL_W-1:0]    iMsl,
    output logic                  iReadMem,
    output logic                  iWriteMem,
    output logic [`BRJ_W-1:0]     iSelBrJumpZ,
    output logic [`PCSEL_W-1:0]   iSelTipoPc,
    output logic [`CMP_W-1:0]     iCompOp
);

    always_comb begin
        iMatch = 1'b0;
        {iSelWSource, iSelRegDest, iWriteReg, iWriteOv, iSelImRegB, iSelSaRegA,
         iSelAluShift, iAluOp, iUnsig, iShiftOp, iMsm, iMsl, iReadMem, iWriteMem,
         iSelBrJumpZ, iSelTipoPc, iCompOp} = '0;
        case (instr.i.op)
            `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI, `OP_XORI: begin
                iMatch = 1'b1;
                iSelImRegB = 1'b1;
                iSelRegDest = `RD_RT;
                iWriteReg = 1'b1;
                // Signed ADDI and SLTI keep the overflow check
                iWriteOv = !(instr.i.op inside {`OP_ADDI, `OP_SLTI});
                case (instr.i.op)
                    `OP_ANDI: iAluOp = `ALU_AND;
                    `OP_ORI:  iAluOp = `ALU_OR;
                    `OP_XORI: iAluOp = `ALU_XOR;
                    `OP_ADDI, `OP_ADDIU: begin
                        iAluOp = `ALU_ADD;
                        iUnsig = instr.i.op[0];
                    end
                    default: begin
                        iAluOp = `ALU_SUB;
                        iUnsig = instr.i.op[0];
                        iSelWSource = `WS_SLT;
                    end
                endcase
            end
            `OP_LUI: begin
                iMatch = 1'b1;
                iSelRegDest = `RD_RT;
                iSelWSource = `WS_LUI;
                iWriteReg = 1'b1;
                iWriteOv = 1'b1;
            end
            `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU: begin
                iMatch = 1'b1;
                iSelImRegB = 1'b1;
                iAluOp = `ALU_ADD;
                iSelRegDest = `RD_RT;
                iSelWSource = `WS_MEM;
                iWriteReg = 1'b1;
                iWriteOv = 1'b1;
                iReadMem = 1'b1;
                case (instr.i.op)
                    `OP_LB:  {iMsm, iMsl} = {`MS_SEL3, `MS_SEL3};
                    `OP_LH:  {iMsm, iMsl} = {`MS_SEL3, `MS_SEL1};
                    `OP_LBU: {iMsm, iMsl} = {`MS_SEL0, `MS_SEL4};
                    `OP_LHU: {iMsm, iMsl} = {`MS_SEL0, `MS_SEL1};
                    default: {iMsm, iMsl} = {`MS_SEL1, `MS_SEL2};
                endcase
            end
            `OP_SB, `OP_SH, `OP_SW: begin
                iMatch = 1'b1;
                iSelImRegB = 1'b1;
                iAluOp = `ALU_ADD;
                iWriteMem = 1'b1;
                case (instr.i.op)
                    `OP_SB:  {iMsm, iMsl} = {`MS_SEL4, `MS_SEL3};
                    `OP_SH:  {iMsm, iMsl} = {`MS_SEL2, `MS_SEL0};
                    default: {iMsm, iMsl} = {`MS_SEL1, `MS_SEL2};
                endcase
            end
            default: ;
        endcase
    end

endmodule

// ==== source/specialDecoder.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module specialDecoder (
    input  decodePkg::instrWord_u instr,
    output logic                  sMatch,
    output logic [`WSRC_W-1:0]    sSelWSource,
    output logic [`RDST_W-1:0]    sSelRegDest,
    output logic                  sWriteReg,
    output logic                  sWriteOv,
    output logic                  sSelImRegB,
    output logic                  sSelSaRegA,
    output logic                  sSelAluShift,
    output logic [`ALUOP_W-1:0]   sAluOp,
    output logic                  sUnsig,
    output logic [`SHOP_W-1:0]    sShiftOp,
    output logic [`MSEL_W-1:0]    sMsm,
    output logic [`MSEL_W-1:0]    sMsl,
    output logic                  sReadMem,
    output logic                  sWriteMem,
    output logic [`BRJ_W-1:0]     sSelBrJumpZ,
    output logic [`PCSEL_W-1:0]   sSelTipoPc,
    output logic [`CMP_W-1:0]     sCompOp
);

    always_comb begin
        sMatch = 1'b0;
        {sSelWSource, sSelRegDest, sWriteReg, sWriteOv, sSelImRegB, sSelSaRegA,
         sSelAluShift, sAluOp, sUnsig, sShiftOp, sMsm, sMsl, sReadMem, sWriteMem,
         sSelBrJumpZ, sSelTipoPc, sCompOp} = '0;
        if (instr.r.op == `OP_SPECIAL) begin
            case (instr.r.fn)
                `FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV: begin
                    sMatch = 1'b1;
                    sSelRegDest = `RD_RD;
                    sWriteReg = 1'b1;
                    sWriteOv = 1'b1;
                    sSelAluShift = 1'b1;
                    // Variable shifts take the amount from rs
                    sSelSaRegA = ~instr.r.fn[2];
                    case (instr.r.fn[1:0])
                        2'b00:   sShiftOp = `SH_SLL;
                        2'b10:   sShiftOp = `SH_SRL;
                        default: sShiftOp = `SH_SRA;
                    endcase
                end
                `FN_JR, `FN_JALR: begin
                    sMatch = 1'b1;
                    sSelBrJumpZ = `BRJ_JUMP;
                    sSelTipoPc = `PC_REG;
                    // JALR links into rd
                    if (instr.r.fn[0]) begin
                        sSelRegDest = `RD_RD;
                        sSelWSource = `WS_LINK;
                        sWriteReg = 1'b1;
                        sWriteOv = 1'b1;
                    end
                end
                `FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_NOR,
                `FN_SLT, `FN_SLTU: begin
                    sMatch = 1'b1;
                    sSelRegDest = `RD_RD;
                    sWriteReg = 1'b1;
                    // Only signed add and subtract trap on overflow
                    sWriteOv = !(instr.r.fn inside {`FN_ADD, `FN_SUB});
                    case (instr.r.fn)
                        `FN_AND: sAluOp = `ALU_AND;
                        `FN_OR:  sAluOp = `ALU_OR;
                        `FN_XOR: sAluOp = `ALU_XOR;
                        `FN_NOR: sAluOp = `ALU_NOR;
                        `FN_ADD, `FN_ADDU: begin
                            sAluOp = `ALU_ADD;
                            sUnsig = instr.r.fn[0];
                        end
                        default: begin
                            sAluOp = `ALU_SUB;
                            sUnsig = instr.r.fn[0];
                            sSelWSource = instr.r.fn[3] ? `WS_SLT : `WS_ALU;
                        end
                    endcase
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== tests/controlUnitTb.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module controlUnitTb;

    localparam int ClkPeriod = 40;
    localparam logic [31:0] IdleWord = 32'hFC00_0000;
    localparam logic [31:0] ResetWord = 32'h8FFF_FFFF;
    localparam logic [31:0] SpecialMask = 32'hFC00_003F;
    localparam logic [31:0] RegimmMask = 32'hFC1F_0000;
    localparam logic [31:0] OpMask = 32'hFC00_0000;

    logic                clk = 1'b0;
    logic                reset;
    logic                instrValid;
    logic [`INSTR_W-1:0] instr;
    logic                ctrlValid;
    logic [`WSRC_W-1:0]  selWSource;
    logic [`RDST_W-1:0]  selRegDest;
    logic                writeReg;
    logic                writeOv;
    logic                selImRegB;
    logic                selSaRegA;
    logic                selAluShift;
    logic [`ALUOP_W-1:0] aluOp;
    logic                unsig;
    logic [`SHOP_W-1:0]  shiftOp;
    logic [`MSEL_W-1:0]  msm;
    logic [`MSEL_W-1:0]  msl;
    logic                readMem;
    logic                writeMem;
    logic [`BRJ_W-1:0]   selBrJumpZ;
    logic [`PCSEL_W-1:0] selTipoPc;
    logic [`CMP_W-1:0]   compOp;

    logic [31:0] seen;
    logic [31:0] rowWord[$];
    logic [31:0] rowMask[$];
    logic        rowValid[$];
    logic [30:0] rowExp[$];
    logic        tableReady = 1'b0;

    controlUnit u_controlUnit (.*);

    always #(ClkPeriod / 2) clk = ~clk;

    assign seen = {ctrlValid, selWSource, selRegDest, writeReg, writeOv, selImRegB, selSaRegA,
                   selAluShift, aluOp, unsig, shiftOp, msm, msl, readMem, writeMem,
                   selBrJumpZ, selTipoPc, compOp};

    function automatic logic [30:0] fields(
        input logic [`WSRC_W-1:0] ws, input logic [`RDST_W-1:0] rd, input logic wr,
        input logic ov, input logic imB, input logic saA, input logic aluSh,
        input logic [`ALUOP_W-1:0] alu, input logic uns, input logic [`SHOP_W-1:0] sh,
        input logic [`MSEL_W-1:0] ms, input logic [`MSEL_W-1:0] ml, input logic rm,
        input logic wm, input logic [`BRJ_W-1:0] brj, input logic [`PCSEL_W-1:0] pc,
        input logic [`CMP_W-1:0] cmp);
        return {ws, rd, wr, ov, imB, saA, aluSh, alu, uns, sh, ms, ml, rm, wm, brj, pc, cmp};
    endfunction

    function automatic logic [30:0] aluRow(input logic [`WSRC_W-1:0] ws,
            input logic [`RDST_W-1:0] rd, input logic ov, input logic imB,
            input logic [`ALUOP_W-1:0] alu, input logic uns);
        return fields(ws, rd, 1'b1, ov, imB, 1'b0, 1'b0, alu, uns, 2'b00, 3'b000, 3'b000,
                      1'b0, 1'b0, 2'b00, 2'b00, 3'b000);
    endfunction

    function automatic logic [30:0] shiftRow(input logic saA, input logic [`SHOP_W-1:0] sh);
        return fields(`WS_ALU, `RD_RD, 1'b1, 1'b1, 1'b0, saA, 1'b1, 3'b000, 1'b0, sh,
                      3'b000, 3'b000, 1'b0, 1'b0, 2'b00, 2'b00, 3'b000);
    endfunction

    function automatic logic [30:0] memRow(input logic load, input logic [`MSEL_W-1:0] ms,
            input logic [`MSEL_W-1:0] ml);
        if (load)
            return fields(`WS_MEM, `RD_RT, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, `ALU_ADD, 1'b0, 2'b00,
                          ms, ml, 1'b1, 1'b0, 2'b00, 2'b00, 3'b000);
        return fields(3'b000, 2'b00, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, `ALU_ADD, 1'b0, 2'b00,
                      ms, ml, 1'b0, 1'b1, 2'b00, 2'b00, 3'b000);
    endfunction

    // Branches and jumps with an optional link write
    function automatic logic [30:0] flowRow(input logic [`BRJ_W-1:0] brj,
            input logic [`PCSEL_W-1:0] pc, input logic [`CMP_W-1:0] cmp, input logic link,
            input logic [`RDST_W-1:0] dest);
        if (link)
            return fields(`WS_LINK, dest, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 3'b000, 1'b0, 2'b00,
                          3'b000, 3'b000, 1'b0, 1'b0, brj, pc, cmp);
        return fields(3'b000, 2'b00, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 3'b000, 1'b0, 2'b00,
                      3'b000, 3'b000, 1'b0, 1'b0, brj, pc, cmp);
    endfunction

    // Invalid words keep their decode but lose register and memory writes
    function automatic logic [30:0] dropStrobes(input logic [30:0] e);
        return e & ~fields(3'b000, 2'b00, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 3'b000, 1'b0, 2'b00,
                           3'b000, 3'b000, 1'b1, 1'b1, 2'b00, 2'b00, 3'b000);
    endfunction

    task automatic addRow(input logic [31:0] word, input logic [31:0] mask, input logic valid,
            input logic [30:0] exp);
        rowWord.push_back(word);
        rowMask.push_back(mask);
        rowValid.push_back(valid);
        rowExp.push_back(exp);
    endtask

    task automatic addSpecial(input logic [`FN_W-1:0] fn, input logic [30:0] exp);
        addRow({`OP_SPECIAL, 20'h0, fn}, SpecialMask, 1'b1, exp);
    endtask

    task automatic addOp(input logic [`OP_W-1:0] op, input logic [30:0] exp);
        addRow({op, 26'h0}, OpMask, 1'b1, exp);
    endtask

    task automatic addRegimm(input logic [`REG_W-1:0] rt, input logic [30:0] exp);
        addRow({`OP_REGIMM, 5'h0, rt, 16'h0}, RegimmMask, 1'b1, exp);
    endtask

    task automatic buildTable();
        addSpecial(`FN_SLL, shiftRow(1'b1, `SH_SLL));
        addSpecial(`FN_SRL, shiftRow(1'b1, `SH_SRL));
        addSpecial(`FN_SRA, shiftRow(1'b1, `SH_SRA));
        addSpecial(`FN_SLLV, shiftRow(1'b0, `SH_SLL));
        addSpecial(`FN_SRLV, shiftRow(1'b0, `SH_SRL));
        addSpecial(`FN_SRAV, shiftRow(1'b0, `SH_SRA));
        addSpecial(`FN_JR, flowRow(`BRJ_JUMP, `PC_REG, `CMP_EQ, 1'b0, `RD_RT));
        addSpecial(`FN_JALR, flowRow(`BRJ_JUMP, `PC_REG, `CMP_EQ, 1'b1, `RD_RD));
        addSpecial(`FN_ADD, aluRow(`WS_ALU, `RD_RD, 1'b0, 1'b0, `ALU_ADD, 1'b0));
        addSpecial(`FN_ADDU, aluRow(`WS_ALU, `RD_RD, 1'b1, 1'b0, `ALU_ADD, 1'b1));
        addSpecial(`FN_SUB, aluRow(`WS_ALU, `RD_RD, 1'b0, 1'b0, `ALU_SUB, 1'b0));
        addSpecial(`FN_SUBU, aluRow(`WS_ALU, `RD_RD, 1'b1, 1'b0, `ALU_SUB, 1'b1));
        addSpecial(`FN_AND, aluRow(`WS_ALU, `RD_RD, 1'b1, 1'b0, `ALU_AND, 1'b0));
        addSpecial(`FN_OR, aluRow(`WS_ALU, `RD_RD, 1'b1, 1'b0, `ALU_OR, 1'b0));
        addSpecial(`FN_XOR, aluRow(`WS_ALU, `RD_RD, 1'b1, 1'b0, `ALU_XOR, 1'b0));
        addSpecial(`FN_NOR, aluRow(`WS_ALU, `RD_RD, 1'b1, 1'b0, `ALU_NOR, 1'b0));
        addSpecial(`FN_SLT, aluRow(`WS_SLT, `RD_RD, 1'b1, 1'b0, `ALU_SUB, 1'b0));
        addSpecial(`FN_SLTU, aluRow(`WS_SLT, `RD_RD, 1'b1, 1'b0, `ALU_SUB, 1'b1));
        addOp(`OP_ADDI, aluRow(`WS_ALU, `RD_RT, 1'b0, 1'b1, `ALU_ADD, 1'b0));
        addOp(`OP_ADDIU, aluRow(`WS_ALU, `RD_RT, 1'b1, 1'b1, `ALU_ADD, 1'b1));
        addOp(`OP_SLTI, aluRow(`WS_SLT, `RD_RT, 1'b0, 1'b1, `ALU_SUB, 1'b0));
        addOp(`OP_SLTIU, aluRow(`WS_SLT, `RD_RT, 1'b1, 1'b1, `ALU_SUB, 1'b1));
        addOp(`OP_ANDI, aluRow(`WS_ALU, `RD_RT, 1'b1, 1'b1, `ALU_AND, 1'b0));
        addOp(`OP_ORI, aluRow(`WS_ALU, `RD_RT, 1'b1, 1'b1, `ALU_OR, 1'b0));
        addOp(`OP_XORI, aluRow(`WS_ALU, `RD_RT, 1'b1, 1'b1, `ALU_XOR, 1'b0));
        addOp(`OP_LUI, aluRow(`WS_LUI, `RD_RT, 1'b1, 1'b0, 3'b000, 1'b0));
        addOp(`OP_LB, memRow(1'b1, `MS_SEL3, `MS_SEL3));
        addOp(`OP_LH, memRow(1'b1, `MS_SEL3, `MS_SEL1));
        addOp(`OP_LW, memRow(1'b1, `MS_SEL1, `MS_SEL2));
        addOp(`OP_LBU, memRow(1'b1, `MS_SEL0, `MS_SEL4));
        addOp(`OP_LHU, memRow(1'b1, `MS_SEL0, `MS_SEL1));
        addOp(`OP_SB, memRow(1'b0, `MS_SEL4, `MS_SEL3));
        addOp(`OP_SH, memRow(1'b0, `MS_SEL2, `MS_SEL0));
        addOp(`OP_SW, memRow(1'b0, `MS_SEL1, `MS_SEL2));
        addOp(`OP_BEQ, flowRow(`BRJ_BRANCH, `PC_BRANCH, `CMP_EQ, 1'b0, `RD_RT));
        addOp(`OP_BNE, flowRow(`BRJ_BRANCH, `PC_BRANCH, `CMP_NE, 1'b0, `RD_RT));
        addOp(`OP_BLEZ, flowRow(`BRJ_BRANCH, `PC_BRANCH, `CMP_LEZ, 1'b0, `RD_RT));
        addOp(`OP_BGTZ, flowRow(`BRJ_BRANCH, `PC_BRANCH, `CMP_GTZ, 1'b0, `RD_RT));
        addRegimm(`RT_BLTZ, flowRow(`BRJ_BRANCH, `PC_BRANCH, `CMP_LTZ, 1'b0, `RD_RT));
        addRegimm(`RT_BGEZ, flowRow(`BRJ_BRANCH, `PC_BRANCH, `CMP_GEZ, 1'b0, `RD_RT));
        addRegimm(`RT_BLTZAL, flowRow(`BRJ_BRANCH, `PC_BRANCH, `CMP_LTZ, 1'b1, `RD_RA));
        addRegimm(`RT_BGEZAL, flowRow(`BRJ_BRANCH, `PC_BRANCH, `CMP_GEZ, 1'b1, `RD_RA));
        addOp(`OP_J, flowRow(`BRJ_JUMP, `PC_TARGET, `CMP_EQ, 1'b0, `RD_RT));
        addOp(`OP_JAL, flowRow(`BRJ_JUMP, `PC_TARGET, `CMP_EQ, 1'b1, `RD_RA));
        // Unknown words including the dropped unaligned and LL/SC opcodes
        addSpecial(6'b001100, 31'h0);
        addSpecial(6'b111111, 31'h0);
        addRegimm(5'b00010, 31'h0);
        addRegimm(5'b10010, 31'h0);
        addOp(6'b010000, 31'h0);
        addOp(6'b111111, 31'h0);
        addOp(6'b100010, 31'h0);
        addOp(6'b100110, 31'h0);
        addOp(6'b101010, 31'h0);
        addOp(6'b101110, 31'h0);
        addOp(6'b110000, 31'h0);
        addOp(6'b111000, 31'h0);
        addRow({`OP_LW, 26'h0}, OpMask, 1'b0, dropStrobes(memRow(1'b1, `MS_SEL1, `MS_SEL2)));
        addRow({`OP_SW, 26'h0}, OpMask, 1'b0, dropStrobes(memRow(1'b0, `MS_SEL1, `MS_SEL2)));
        addRow({`OP_SPECIAL, 20'h0, `FN_ADD}, SpecialMask, 1'b0,
               dropStrobes(aluRow(`WS_ALU, `RD_RD, 1'b0, 1'b0, `ALU_ADD, 1'b0)));
        addOp(`OP_ORI, aluRow(`WS_ALU, `RD_RT, 1'b1, 1'b1, `ALU_OR, 1'b0));
    endtask

    task automatic checkEqual(input string what, input logic [31:0] got,
            input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    initial begin
        logic [31:0] fill;
        void'($urandom(32'h26790c05));
        reset = 1'b1;
        // Reset has to override a valid load word
        instrValid = 1'b1;
        instr = ResetWord;
        buildTable();
        tableReady = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        instrValid <= 1'b0;
        instr <= IdleWord;
        @(negedge clk);
        checkEqual("after reset", seen, 32'h0);
        // Rows go in back to back and each is checked on the cycle after it enters
        for (int i = 0; i <= rowWord.size(); i++) begin
            fill = $urandom();
            @(posedge clk);
            if (i < rowWord.size()) begin
                instr <= (rowWord[i] & rowMask[i]) | (fill & ~rowMask[i]);
                instrValid <= rowValid[i];
            end else begin
                instr <= IdleWord;
                instrValid <= 1'b0;
            end
            @(negedge clk);
            if (i > 0)
                checkEqual($sformatf("row %0d", i - 1), seen, {rowValid[i-1], rowExp[i-1]});
        end
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        wait (tableReady);
        #((rowWord.size() + 20) * ClkPeriod);
        $display("Watchdog timeout: the run did not finish in time");
        $display("Result: FAILED");
        $fatal(1);
    end

endmodule
